//--- build.f
+incdir+.
mem_pkg.sv
store_align.sv
data_memory.sv
mem_stage.sv
writeback_stage.sv
mem_wb_top.sv
tb_mem_wb.sv

//--- Makefile
# Verilator flow for the MEM/WB pipeline testbench

TOP = tb_mem_wb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

# build, run, and pass only when the pass line shows up
sim:
	verilator --binary --timing -j 0 -f build.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

//--- tb_mem_wb_vectors.svh
// columns: test, step enable, op, address, store data, destination,
// reg_write, mem_to_reg, random store data, expected write enable
task automatic load_vectors();
   test_name[1] = "reset state";
   test_name[2] = "word store and load";
   test_name[3] = "byte and halfword lanes";
   test_name[4] = "alu writeback";
   test_name[5] = "step enable freeze";
   test_name[6] = "back-to-back";

   // random words, 0x2404 wraps onto 0x404
   add_row(2, 1, MEM_SW,  32'h0000_0010, 32'h0000_0000,  0, 0, 0, 1, 0);
   add_row(2, 1, MEM_SW,  32'h0000_0ffc, 32'h0000_0000,  0, 0, 0, 1, 0);
   add_row(2, 1, MEM_SW,  32'h0000_2404, 32'h0000_0000,  0, 0, 0, 1, 0);
   add_row(2, 1, MEM_LW,  32'h0000_0010, 32'h0000_0000,  3, 1, 1, 0, 1);
   add_row(2, 1, MEM_LW,  32'h0000_0ffc, 32'h0000_0000,  4, 1, 1, 0, 1);
   add_row(2, 1, MEM_LW,  32'h0000_0404, 32'h0000_0000,  5, 1, 1, 0, 1);
   // alias store overwrites word 0x010
   add_row(2, 1, MEM_SW,  32'h0000_1010, 32'h0000_0000,  0, 0, 0, 1, 0);
   add_row(2, 1, MEM_LW,  32'h0000_0010, 32'h0000_0000,  6, 1, 1, 0, 1);
   add_row(2, 1, MEM_LW,  32'habc0_0ffc, 32'h0000_0000,  7, 1, 1, 0, 1);

   // base words, then one byte store per offset
   add_row(3, 1, MEM_SW,  32'h0000_0100, 32'h1122_3344,  0, 0, 0, 0, 0);
   add_row(3, 1, MEM_SW,  32'h0000_0104, 32'h5566_7788,  0, 0, 0, 0, 0);
   add_row(3, 1, MEM_SB,  32'h0000_0100, 32'h0000_007f,  0, 0, 0, 0, 0);
   add_row(3, 1, MEM_SB,  32'h0000_0101, 32'h0000_00a5,  0, 0, 0, 0, 0);
   add_row(3, 1, MEM_SB,  32'h0000_0102, 32'h0000_0001,  0, 0, 0, 0, 0);
   add_row(3, 1, MEM_SB,  32'h0000_0103, 32'hffff_ff80,  0, 0, 0, 0, 0);
   add_row(3, 1, MEM_LW,  32'h0000_0100, 32'h0000_0000,  8, 1, 1, 0, 1);
   // halfword at each offset, upper store bits must not leak
   add_row(3, 1, MEM_SH,  32'h0000_0104, 32'h0000_1234,  0, 0, 0, 0, 0);
   add_row(3, 1, MEM_SH,  32'h0000_0105, 32'h9999_4321,  0, 0, 0, 0, 0);
   add_row(3, 1, MEM_SH,  32'h0000_0106, 32'h0000_beef,  0, 0, 0, 0, 0);
   add_row(3, 1, MEM_SH,  32'h0000_0107, 32'h1111_cafe,  0, 0, 0, 0, 0);
   add_row(3, 1, MEM_LW,  32'h0000_0104, 32'h0000_0000,  9, 1, 1, 0, 1);
   // sign and zero extension
   add_row(3, 1, MEM_LB,  32'h0000_0103, 32'h0000_0000, 10, 1, 1, 0, 1);
   add_row(3, 1, MEM_LBU, 32'h0000_0103, 32'h0000_0000, 11, 1, 1, 0, 1);
   add_row(3, 1, MEM_LB,  32'h0000_0100, 32'h0000_0000, 12, 1, 1, 0, 1);
   add_row(3, 1, MEM_LBU, 32'h0000_0101, 32'h0000_0000, 13, 1, 1, 0, 1);
   add_row(3, 1, MEM_LB,  32'h0000_0102, 32'h0000_0000, 14, 1, 1, 0, 1);
   add_row(3, 1, MEM_LH,  32'h0000_0106, 32'h0000_0000, 15, 1, 1, 0, 1);
   add_row(3, 1, MEM_LHU, 32'h0000_0107, 32'h0000_0000, 16, 1, 1, 0, 1);
   add_row(3, 1, MEM_LH,  32'h0000_0105, 32'h0000_0000, 17, 1, 1, 0, 1);
   add_row(3, 1, MEM_LHU, 32'h0000_0104, 32'h0000_0000, 18, 1, 1, 0, 1);

   // alu results, r0 never written
   add_row(4, 1, MEM_NOP, 32'hdead_beef, 32'h0000_0000, 20, 1, 0, 0, 1);
   add_row(4, 1, MEM_NOP, 32'h0000_1234, 32'h0000_0000,  0, 1, 0, 0, 0);
   add_row(4, 1, MEM_NOP, 32'h8000_0001, 32'h0000_0000, 31, 0, 0, 0, 0);
   add_row(4, 1, MEM_NOP, 32'hffff_fffc, 32'h0000_0000, 31, 1, 0, 0, 1);

   // outputs hold the last load while a store and another word's load sit frozen
   add_row(5, 1, MEM_SW,  32'h0000_0200, 32'hcafe_f00d,  0, 0, 0, 0, 0);
   add_row(5, 1, MEM_LW,  32'h0000_0200, 32'h0000_0000, 21, 1, 1, 0, 1);
   add_row(5, 0, MEM_SW,  32'h0000_0200, 32'h0bad_beef,  0, 0, 0, 0, 1);
   add_row(5, 0, MEM_LW,  32'h0000_0100, 32'h0000_0000, 22, 1, 1, 0, 1);
   add_row(5, 1, MEM_LW,  32'h0000_0200, 32'h0000_0000, 23, 1, 1, 0, 1);

   // store then load of the same word on the next edge
   add_row(6, 1, MEM_SW,  32'h0000_0300, 32'h0000_0000,  0, 0, 0, 1, 0);
   add_row(6, 1, MEM_LW,  32'h0000_0300, 32'h0000_0000, 24, 1, 1, 0, 1);
   add_row(6, 1, MEM_SB,  32'h0000_0301, 32'h0000_0000,  0, 0, 0, 1, 0);
   add_row(6, 1, MEM_LBU, 32'h0000_0301, 32'h0000_0000, 25, 1, 1, 0, 1);
   add_row(6, 1, MEM_SH,  32'h0000_0302, 32'h0000_0000,  0, 0, 0, 1, 0);
   add_row(6, 1, MEM_LH,  32'h0000_0302, 32'h0000_0000, 26, 1, 1, 0, 1);
   add_row(6, 1, MEM_SW,  32'h0000_1304, 32'h0000_0000,  0, 0, 0, 1, 0);
   add_row(6, 1, MEM_LW,  32'h0000_0304, 32'h0000_0000, 27, 1, 1, 0, 1);
   add_row(6, 1, MEM_LB,  32'h0000_0307, 32'h0000_0000, 28, 1, 1, 0, 1);
   add_row(6, 1, MEM_SB,  32'h0000_0304, 32'h0000_0000,  0, 0, 0, 1, 0);
   add_row(6, 1, MEM_LW,  32'h0000_0304, 32'h0000_0000, 29, 1, 1, 0, 1);
endtask

//--- tb_mem_wb.sv
`timescale 1ns/1ps

module tb_mem_wb
   import mem_pkg::*;
   ();

   localparam int NB_DEPTH     = 10;
   // byte-addressed reference space, same wrap as the DUT
   localparam int MEM_BYTES    = 2**(NB_DEPTH+NB_OFF);
   localparam int RESET_CYCLES = 10;
   // clock transitions allowed per wait
   localparam int EDGE_LIMIT   = 4;
   localparam int WATCHDOG_NS  = 100000;

   // one table row
   typedef struct packed {
      logic [3:0]          test;
      logic                step;
      mem_op_e             op;
      logic [NB_DATA-1:0]  addr;
      logic [NB_DATA-1:0]  wdata;
      logic [NB_REG-1:0]   dst;
      logic                rw;
      logic                m2r;
      logic                rnd;
      logic                exp_we;
   } vec_t;

   logic          i_clk = 1'b0;
   logic          i_rst;
   logic          i_step_en;
   mem_req_t      i_req;
   rf_write_t     o_rf_write;
   mem_wb_t       o_wb_bus;

   vec_t                vectors[$];
   string               test_name [1:6];
   // reference memory, one entry per byte
   logic [7:0]          ref_mem [MEM_BYTES];
   logic [31:0]         rng_state;
   // last expected outputs, repeated while frozen
   rf_write_t           prev_rf;
   mem_wb_t             prev_wb;
   int                  error_count;
   int                  check_count;
   int                  test_errs;
   int                  tests_clean;
   int                  tests_run;

   mem_wb_top #(
      .NB_DEPTH      (NB_DEPTH)
   ) UUT (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_step_en     (i_step_en),
      .i_req         (i_req),
      .o_rf_write    (o_rf_write),
      .o_wb_bus      (o_wb_bus)
   );

   // 40 ns period
   always #20 i_clk = ~i_clk;

   initial begin : watchdog
      #(WATCHDOG_NS);
      abort_run("simulation ran past its time limit");
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Regression failed");
      $finish;
   endtask

   // returns right at the transition to the requested level
   task automatic wait_level(input logic level, input string what);
      int   guard;
      logic reached;
      guard   = 0;
      reached = 1'b0;
      while (!reached && guard < EDGE_LIMIT) begin
         @(i_clk);
         guard++;
         reached = (i_clk === level);
      end
      if (!reached) begin
         abort_run($sformatf("clock stopped while waiting for %s", what));
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   task automatic add_row(input int test, input int step, input mem_op_e op,
                          input logic [NB_DATA-1:0] addr, input logic [NB_DATA-1:0] wdata,
                          input int dst, input int rw, input int m2r, input int rnd,
                          input int exp_we);
      vec_t v;
      v.test   = test[3:0];
      v.step   = (step != 0);
      v.op     = op;
      v.addr   = addr;
      v.wdata  = wdata;
      v.dst    = dst[NB_REG-1:0];
      v.rw     = (rw != 0);
      v.m2r    = (m2r != 0);
      v.rnd    = (rnd != 0);
      v.exp_we = (exp_we != 0);
      vectors.push_back(v);
   endtask

   // little-endian byte writes, halfword ignores addr bit 0
   task automatic ref_store(input mem_req_t req);
      logic [NB_DEPTH-1:0] wi;
      logic [1:0]          off;
      wi  = req.addr[NB_DEPTH+1:2];
      off = req.addr[1:0];
      case (req.op)
         MEM_SB: ref_mem[{wi, off}] = req.wdata[7:0];
         MEM_SH: begin
            ref_mem[{wi, off[1], 1'b0}] = req.wdata[7:0];
            ref_mem[{wi, off[1], 1'b1}] = req.wdata[15:8];
         end
         MEM_SW: begin
            ref_mem[{wi, 2'd0}] = req.wdata[7:0];
            ref_mem[{wi, 2'd1}] = req.wdata[15:8];
            ref_mem[{wi, 2'd2}] = req.wdata[23:16];
            ref_mem[{wi, 2'd3}] = req.wdata[31:24];
         end
         default: begin
         end
      endcase
   endtask

   function automatic logic [31:0] ref_load(input mem_op_e op, input logic [31:0] addr);
      logic [NB_DEPTH-1:0] wi;
      logic [1:0]          off;
      logic [7:0]          b;
      logic [15:0]         h;
      logic [31:0]         w;
      wi  = addr[NB_DEPTH+1:2];
      off = addr[1:0];
      b   = ref_mem[{wi, off}];
      h   = {ref_mem[{wi, off[1], 1'b1}], ref_mem[{wi, off[1], 1'b0}]};
      w   = {ref_mem[{wi, 2'd3}], ref_mem[{wi, 2'd2}], ref_mem[{wi, 2'd1}], ref_mem[{wi, 2'd0}]};
      case (op)
         MEM_LB:  return {{24{b[7]}}, b};
         MEM_LBU: return {24'd0, b};
         MEM_LH:  return {{16{h[15]}}, h};
         MEM_LHU: return {16'd0, h};
         default: return w;
      endcase
   endfunction

   // expected outputs one clock after the row is presented
   task automatic predict(input mem_req_t req, input logic step, input logic exp_we,
                          output rf_write_t exp_rf, output mem_wb_t exp_wb);
      if (!step) begin
         // frozen, nothing captured
         exp_rf = prev_rf;
         exp_wb = prev_wb;
      end else begin
         ref_store(req);
         exp_wb.wb       = req.wb;
         exp_wb.alu_data = req.addr;
         exp_wb.reg_dst  = req.reg_dst;
         exp_wb.load_op  = req.op;
         exp_wb.byte_off = req.addr[1:0];
         exp_rf.addr     = req.reg_dst;
         exp_rf.data     = req.wb.mem_to_reg ? ref_load(req.op, req.addr) : req.addr;
      end
      exp_rf.we = exp_we;
      prev_rf   = exp_rf;
      prev_wb   = exp_wb;
   endtask

   task automatic check_rf_write(input rf_write_t got, input rf_write_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         test_errs++;
         $display(
            "FAILED t=%0t o_rf_write: got we=%b addr=%0d data=%h, expected we=%b addr=%0d data=%h",
            $time, got.we, got.addr, got.data, exp.we, exp.addr, exp.data);
      end
   endtask

   task automatic check_wb_bus(input mem_wb_t got, input mem_wb_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         test_errs++;
         $display("FAILED t=%0t o_wb_bus: got %h, expected %h", $time, got, exp);
      end
   endtask

   task automatic report_test(input logic [3:0] id);
      tests_run++;
      if (test_errs == 0) begin
         tests_clean++;
         $display("test %0d %s: ok", id, test_name[id]);
      end else begin
         $display("test %0d %s: %0d mismatches", id, test_name[id], test_errs);
      end
      test_errs = 0;
   endtask

   `include "tb_mem_wb_vectors.svh"

   initial begin : stimulus
      mem_req_t   req;
      rf_write_t  pend_rf;
      mem_wb_t    pend_wb;
      logic [3:0] pend_test;
      logic       have_pend;
      int         n;
      i_rst       = 1'b1;
      i_step_en   = 1'b1;
      i_req       = '0;
      rng_state   = 32'had55;
      error_count = 0;
      check_count = 0;
      test_errs   = 0;
      tests_clean = 0;
      tests_run   = 0;
      prev_rf     = '0;
      prev_wb     = '0;
      have_pend   = 1'b0;
      pend_test   = 4'd0;
      req         = '0;
      load_vectors();
      n = vectors.size();
      for (int c = 0; c < RESET_CYCLES; c++) begin
         wait_level(1'b1, "reset cycle");
      end
      i_rst <= 1'b0;
      // reset values still showing, nothing captured yet
      wait_level(1'b0, "reset check");
      check_rf_write(o_rf_write, '0);
      check_wb_bus(o_wb_bus, '0);
      report_test(4'd1);
      // row i goes in while row i-1 is checked
      for (int i = 0; i <= n; i++) begin
         wait_level(1'b1, "row edge");
         if (i < n) begin
            req.op      = vectors[i].op;
            req.addr    = vectors[i].addr;
            req.reg_dst = vectors[i].dst;
            req.wb.reg_write  = vectors[i].rw;
            req.wb.mem_to_reg = vectors[i].m2r;
            if (vectors[i].rnd) begin
               rng_state = xorshift32(rng_state);
               req.wdata = rng_state;
            end else begin
               req.wdata = vectors[i].wdata;
            end
            i_req     <= req;
            i_step_en <= vectors[i].step;
         end else begin
            // idle tail flushes the last row
            i_req     <= '0;
            i_step_en <= 1'b1;
         end
         if (have_pend) begin
            // falling edge, outputs settled
            wait_level(1'b0, "sample point");
            check_rf_write(o_rf_write, pend_rf);
            check_wb_bus(o_wb_bus, pend_wb);
            if (i == n || vectors[i].test != pend_test) begin
               report_test(pend_test);
            end
         end
         if (i < n) begin
            predict(req, vectors[i].step, vectors[i].exp_we, pend_rf, pend_wb);
            pend_test = vectors[i].test;
            have_pend = 1'b1;
         end
      end
      $display("%0d of %0d tests clean, %0d checks, %0d errors",
               tests_clean, tests_run, check_count, error_count);
      if (error_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- mem_wb_top.sv
`timescale 1ns/1ps

module mem_wb_top
   import mem_pkg::*;
   #(
   // log2 of the data memory word count
   parameter int NB_DEPTH = 10
   )
   (
   input  logic         i_clk,
   input  logic         i_rst,
   // debug step enable, low freezes the stage
   input  logic         i_step_en,
   // one request per cycle from execute
   input  mem_req_t     i_req,
   // register file write port
   output rf_write_t    o_rf_write,
   // MEM/WB register for forwarding and debug
   output mem_wb_t      o_wb_bus
   );

   // pipeline register between the stages
   mem_wb_t                mem_wb;
   // raw word from the memory read register
   logic [NB_DATA-1:0]     mem_rdata;

   // memory access and MEM/WB register
   mem_stage #(
      .NB_DEPTH      (NB_DEPTH)
   ) u_mem_stage (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_step_en     (i_step_en),
      .i_req         (i_req),
      .o_mem_wb      (mem_wb),
      .o_mem_rdata   (mem_rdata)
   );

   // lane select, extension and result mux
   writeback_stage u_writeback_stage (
      .i_mem_wb      (mem_wb),
      .i_mem_rdata   (mem_rdata),
      .o_rf_write    (o_rf_write)
   );

   // pipeline register also goes out for the forwarding paths
   assign o_wb_bus = mem_wb;

endmodule

//--- writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage
   import mem_pkg::*;
   (
   input  mem_wb_t               i_mem_wb,
   input  logic [NB_DATA-1:0]    i_mem_rdata,
   output rf_write_t             o_rf_write
   );

   // selected byte and halfword lanes
   logic [NB_BYTE-1:0]     ld_byte;
   logic [2*NB_BYTE-1:0]   ld_half;
   // extended load result
   logic [NB_DATA-1:0]     ld_data;
   // value headed for the register file
   logic [NB_DATA-1:0]     wr_data;

   // byte lane from the full offset, lane 0 is the low byte
   always_comb begin
      case (i_mem_wb.byte_off)
         2'd0: ld_byte = i_mem_rdata[7:0];
         2'd1: ld_byte = i_mem_rdata[15:8];
         2'd2: ld_byte = i_mem_rdata[23:16];
         default: ld_byte = i_mem_rdata[31:24];
      endcase
   end

   // halfword lane, offset bit 0 ignored
   assign ld_half = i_mem_wb.byte_off[1] ? i_mem_rdata[31:16] : i_mem_rdata[15:0];

   // sign or zero extension per load op
   always_comb begin
      case (i_mem_wb.load_op)
         MEM_LB: begin
            ld_data = {{(NB_DATA-NB_BYTE){ld_byte[NB_BYTE-1]}}, ld_byte};
         end
         MEM_LBU: begin
            ld_data = {{(NB_DATA-NB_BYTE){1'b0}}, ld_byte};
         end
         MEM_LH: begin
            ld_data = {{(NB_DATA-2*NB_BYTE){ld_half[2*NB_BYTE-1]}}, ld_half};
         end
         MEM_LHU: begin
            ld_data = {{(NB_DATA-2*NB_BYTE){1'b0}}, ld_half};
         end
         MEM_LW: begin
            ld_data = i_mem_rdata;
         end
         default: begin
            // not a load, raw word passes through
            ld_data = i_mem_rdata;
         end
      endcase
   end

   // memory data or ALU result
   assign wr_data = i_mem_wb.wb.mem_to_reg ? ld_data : i_mem_wb.alu_data;

   // r0 is hardwired, never written
   assign o_rf_write.we   = i_mem_wb.wb.reg_write && (i_mem_wb.reg_dst != '0);
   assign o_rf_write.addr = i_mem_wb.reg_dst;
   assign o_rf_write.data = wr_data;

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage
   import mem_pkg::*;
   #(
   parameter int NB_DEPTH = 10
   )
   (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_step_en,
   input  mem_req_t              i_req,
   output mem_wb_t               o_mem_wb,
   output logic [NB_DATA-1:0]    o_mem_rdata
   );

   // word index, upper address bits dropped so addresses wrap
   logic [NB_DEPTH-1:0]    word_idx;
   // byte position inside the word
   logic [NB_OFF-1:0]      byte_off;
   // read strobe for load ops
   logic                   rd_en;

   // store lanes after alignment
   logic [NB_LANES-1:0]    byte_we;
   logic [NB_DATA-1:0]     lane_data;

   // MEM/WB register
   mem_wb_t                mem_wb;

   assign word_idx = i_req.addr[NB_DEPTH+NB_OFF-1:NB_OFF];
   assign byte_off = i_req.addr[NB_OFF-1:0];
   assign rd_en    = is_load(i_req.op);

   // byte enables and replicated data for stores
   store_align u_store_align (
      .i_op          (i_req.op),
      .i_byte_off    (byte_off),
      .i_wdata       (i_req.wdata),
      .o_byte_we     (byte_we),
      .o_lane_data   (lane_data)
   );

   // step enable freezes writes and the read register
   data_memory #(
      .NB_DEPTH      (NB_DEPTH)
   ) u_data_memory (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_en          (i_step_en),
      .i_addr        (word_idx),
      .i_byte_we     (byte_we),
      .i_wdata       (lane_data),
      .i_rd_en       (rd_en),
      .o_rdata       (o_mem_rdata)
   );

   // pipeline register to writeback
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         mem_wb <= '0;
      end else if (i_step_en) begin
         mem_wb.wb       <= i_req.wb;
         // address doubles as the ALU result for non-memory ops
         mem_wb.alu_data <= i_req.addr;
         mem_wb.reg_dst  <= i_req.reg_dst;
         // op and offset steer lane select in writeback
         mem_wb.load_op  <= i_req.op;
         mem_wb.byte_off <= byte_off;
      end
   end

   assign o_mem_wb = mem_wb;

endmodule

//--- data_memory.sv
`timescale 1ns/1ps

module data_memory
   import mem_pkg::*;
   #(
   parameter int NB_DEPTH = 10
   )
   (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_en,
   input  logic [NB_DEPTH-1:0]   i_addr,
   input  logic [NB_LANES-1:0]   i_byte_we,
   input  logic [NB_DATA-1:0]    i_wdata,
   input  logic                  i_rd_en,
   output logic [NB_DATA-1:0]    o_rdata
   );

   localparam int NB_WORDS = 2**NB_DEPTH;

   // word assembled from the four columns
   logic [NB_DATA-1:0] rd_word;

   // one 8-bit column per lane, all share the word address
   for (genvar c = 0; c < NB_LANES; c++) begin : g_col
      logic [NB_BYTE-1:0] col_ram [NB_WORDS];

      // column write, only on enabled edges
      always_ff @(posedge i_clk) begin
         if (i_en && i_byte_we[c]) begin
            col_ram[i_addr] <= i_wdata[c*NB_BYTE +: NB_BYTE];
         end
      end

      // old contents seen here on a same-edge write
      assign rd_word[c*NB_BYTE +: NB_BYTE] = col_ram[i_addr];
   end

   // registered read port
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_rdata <= '0;
      end else if (i_en && i_rd_en) begin
         o_rdata <= rd_word;
      end
   end

endmodule

//--- store_align.sv
`timescale 1ns/1ps

module store_align
   import mem_pkg::*;
   (
   input  mem_op_e               i_op,
   input  logic [NB_OFF-1:0]     i_byte_off,
   input  logic [NB_DATA-1:0]    i_wdata,
   output logic [NB_LANES-1:0]   o_byte_we,
   output logic [NB_DATA-1:0]    o_lane_data
   );

   // low byte and halfword of the store data
   logic [NB_BYTE-1:0]     st_byte;
   logic [2*NB_BYTE-1:0]   st_half;

   assign st_byte = i_wdata[NB_BYTE-1:0];
   assign st_half = i_wdata[2*NB_BYTE-1:0];

   always_comb begin
      // non-store ops leave memory alone
      o_byte_we   = '0;
      o_lane_data = i_wdata;
      case (i_op)
         MEM_SB: begin
            // one-hot lane at the byte offset
            o_byte_we   = 4'b0001 << i_byte_off;
            // every lane carries the byte, mask picks one
            o_lane_data = {NB_LANES{st_byte}};
         end
         MEM_SH: begin
            // bit 0 ignored, lane pair 0/1 or 2/3
            if (i_byte_off[1]) begin
               o_byte_we = 4'b1100;
            end else begin
               o_byte_we = 4'b0011;
            end
            o_lane_data = {(NB_LANES/2){st_half}};
         end
         MEM_SW: begin
            // whole word, offset ignored
            o_byte_we   = '1;
            o_lane_data = i_wdata;
         end
         default: begin
            o_byte_we   = '0;
            o_lane_data = i_wdata;
         end
      endcase
   end

endmodule

//--- mem_pkg.sv
package mem_pkg;

   // datapath and address width
   localparam int NB_DATA  = 32;
   // register file index
   localparam int NB_REG   = 5;
   // byte lanes per word
   localparam int NB_BYTE  = 8;
   localparam int NB_LANES = NB_DATA / NB_BYTE;
   // byte offset bits inside a word
   localparam int NB_OFF   = 2;

   // memory operations carried from execute
   typedef enum logic [3:0] {
      MEM_NOP = 4'd0,
      MEM_LB  = 4'd1,
      MEM_LBU = 4'd2,
      MEM_LH  = 4'd3,
      MEM_LHU = 4'd4,
      MEM_LW  = 4'd5,
      MEM_SB  = 4'd6,
      MEM_SH  = 4'd7,
      MEM_SW  = 4'd8
   } mem_op_e;

   // writeback control
   typedef struct packed {
      logic reg_write;
      logic mem_to_reg;
   } wb_ctl_t;

   // request from execute, 75 bits
   typedef struct packed {
      mem_op_e              op;
      logic [NB_DATA-1:0]   addr;
      logic [NB_DATA-1:0]   wdata;
      logic [NB_REG-1:0]    reg_dst;
      wb_ctl_t              wb;
   } mem_req_t;

   // MEM/WB pipeline register, 45 bits
   typedef struct packed {
      wb_ctl_t              wb;
      logic [NB_DATA-1:0]   alu_data;
      logic [NB_REG-1:0]    reg_dst;
      mem_op_e              load_op;
      logic [NB_OFF-1:0]    byte_off;
   } mem_wb_t;

   // register file write port, 38 bits
   typedef struct packed {
      logic                 we;
      logic [NB_REG-1:0]    addr;
      logic [NB_DATA-1:0]   data;
   } rf_write_t;

   // true for any op that reads the data memory
   function automatic logic is_load(input mem_op_e op);
      return (op == MEM_LB) || (op == MEM_LBU) || (op == MEM_LH) ||
             (op == MEM_LHU) || (op == MEM_LW);
   endfunction

endpackage
